//--- Makefile
# Verilator build and run of the pong link board.
TOP = tb_pong_board

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f pong_link.f --top-module $(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only --timing -Wall -f pong_link.f --top-module pong_board

clean:
	rm -rf obj_dir sim.log

//--- ball_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "pong_link_macros.svh"

module ball_controller import pong_geom_pkg::*, pong_link_pkg::*; #(
    parameter period_t tick_base = 20'd270000
) (
    input  logic      clk_25MHZ,
    input  logic      reset,
    input  logic      upscale,
    input  logic      game_start,
    input  logic      hit,
    input  coord_t    paddle_speed,
    input  logic      rx_valid,
    input  ball_pkt_t rx_pkt,
    input  logic      send_done,
    output ball_t     ball,
    output logic      moving_left,
    output logic      rx_take,
    output logic      send_req,
    output ball_pkt_t tx_pkt,
    output logic      game_over,
    output logic      you_win
);

    ctrl_state_t        state, next;
    ball_t              ball_next, ball_step;
    period_t            period, period_next;
    period_t            step_cnt, step_cnt_next;
    logic               send_req_next, game_over_next, you_win_next;
    logic               step_due;
    coord_t             y_max, x_right, speed_safe;
    logic signed [11:0] y_sum;

    assign y_max       = upscale ? coord_t'(`PONG_Y_MAX_UP) : coord_t'(`PONG_Y_MAX_NORMAL);
    assign x_right     = upscale ? coord_t'(`PONG_X_RIGHT_UP) : coord_t'(`PONG_X_RIGHT_NORMAL);
    assign step_due    = (step_cnt >= period);
    assign speed_safe  = (paddle_speed == '0) ? coord_t'(1) : paddle_speed;
    assign moving_left = (state == running_left);

    // One step of gravity and wall bounce. The FSM moves x.
    always_comb begin
        ball_step = ball;
        if (ball.grav == 2'd3) begin
            ball_step.vy   = ball.vy + 8'sd1;
            ball_step.grav = '0;
        end else begin
            ball_step.grav = ball.grav + 2'd1;
        end
        y_sum = $signed({2'b00, ball.y}) + 12'($signed(ball.vy));  // Old vy.
        if (y_sum >= $signed({2'b00, y_max})) begin
            ball_step.y    = y_max;
            ball_step.vy   = -ball_step.vy;
            ball_step.grav = '0;
        end else if (y_sum <= $signed(12'(`PONG_Y_MIN))) begin
            ball_step.y    = coord_t'(`PONG_Y_MIN);
            ball_step.vy   = -ball_step.vy;
            ball_step.grav = '0;
        end else begin
            ball_step.y = y_sum[9:0];
        end
    end

    always_comb begin
        next           = state;
        ball_next      = ball;
        period_next    = period;
        step_cnt_next  = step_cnt;
        send_req_next  = send_req;
        game_over_next = game_over;
        you_win_next   = you_win;
        rx_take        = 1'b0;
        case (state)
            idle: begin
                ball_next     = '{x: '0, y: coord_t'(`PONG_Y_START),
                                  vy: vel_t'(`PONG_VY_START), grav: '0};
                period_next   = tick_base;
                step_cnt_next = '0;
                if (rx_valid) begin  // Ball arrives from the opponent.
                    rx_take        = 1'b1;
                    ball_next.x    = x_right;
                    ball_next.y    = rx_pkt.y;
                    ball_next.vy   = rx_pkt.vy;
                    ball_next.grav = rx_pkt.grav;
                    period_next    = rx_pkt.fast ? tick_base : tick_base >> 1;
                    you_win_next   = rx_pkt.win;
                    next           = wait_release;
                end else if (game_start) begin
                    you_win_next = 1'b0;
                    next         = running_right;
                end
            end
            wait_release: begin
                if (!rx_valid) next = you_win ? idle : running_left;
            end
            running_right: begin
                if (ball.x >= x_right) begin
                    send_req_next = 1'b1;
                    next          = send_ball;
                end else if (step_due) begin
                    ball_next     = ball_step;
                    ball_next.x   = ball.x + coord_t'(`PONG_X_STEP);
                    step_cnt_next = '0;
                end else begin
                    step_cnt_next = step_cnt + 20'd1;
                end
            end
            running_left: begin
                if (hit) begin  // Faster paddle, shorter period.
                    period_next   = tick_base / period_t'(speed_safe);
                    step_cnt_next = '0;
                    next          = running_right;
                end else if (ball.x == '0) begin
                    send_req_next  = 1'b1;
                    game_over_next = 1'b1;
                    next           = send_lose;
                end else if (step_due) begin
                    ball_next     = ball_step;
                    ball_next.x   = (ball.x < `PONG_X_STEP) ? '0
                                  : ball.x - coord_t'(`PONG_X_STEP);
                    step_cnt_next = '0;
                end else begin
                    step_cnt_next = step_cnt + 20'd1;
                end
            end
            send_ball: begin
                if (send_done) begin
                    send_req_next = 1'b0;
                    next          = idle;
                end
            end
            send_lose: begin
                if (send_done) begin
                    send_req_next = 1'b0;
                    next          = stop;
                end
            end
            stop: begin
                if (game_start) begin
                    game_over_next = 1'b0;
                    next           = idle;
                end
            end
            default: next = idle;
        endcase
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state     <= idle;
            ball      <= '{x: '0, y: coord_t'(`PONG_Y_START),
                           vy: vel_t'(`PONG_VY_START), grav: '0};
            period    <= tick_base;
            step_cnt  <= '0;
            send_req  <= 1'b0;
            game_over <= 1'b0;
            you_win   <= 1'b0;
        end else begin
            state     <= next;
            ball      <= ball_next;
            period    <= period_next;
            step_cnt  <= step_cnt_next;
            send_req  <= send_req_next;
            game_over <= game_over_next;
            you_win   <= you_win_next;
        end
    end

    always_comb begin
        tx_pkt.y    = ball.y;
        tx_pkt.vy   = ball.vy;
        tx_pkt.grav = ball.grav;
        tx_pkt.fast = (period == tick_base);
        tx_pkt.win  = (state == send_lose);  // Opponent takes the match.
    end

    a_y_in_field: assert property (@(posedge clk_25MHZ) disable iff (reset)
        (ball.y >= `PONG_Y_MIN) && (ball.y <= y_max))
        else $error("ball y outside the play field");

    a_req_hold: assert property (@(posedge clk_25MHZ) disable iff (reset)
        send_req && !send_done |=> send_req)
        else $error("send_req dropped before send_done");

endmodule

`default_nettype wire

//--- link_receiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "pong_link_macros.svh"

module link_receiver import pong_link_pkg::*; (
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  apb_req_t    apb,
    input  logic        rx_take,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        rx_valid,
    output ball_pkt_t   rx_pkt
);

    logic access;
    logic wr;
    logic rd_ok;
    logic wr_ok;
    logic overrun;

    assign access = apb.psel && apb.penable;
    assign wr     = access && apb.pwrite;
    assign pready = 1'b1;  // No wait states.

    always_comb begin
        prdata = '0;
        rd_ok  = 1'b1;
        wr_ok  = 1'b1;
        case (apb.paddr)
            `PONG_REG_Y:      prdata = {22'd0, rx_pkt.y};
            `PONG_REG_VY:     prdata = {{24{rx_pkt.vy[7]}}, rx_pkt.vy};
            `PONG_REG_GRAV:   prdata = {30'd0, rx_pkt.grav};
            `PONG_REG_FLAGS:  prdata = {30'd0, rx_pkt.win, rx_pkt.fast};
            `PONG_REG_COMMIT: rd_ok  = 1'b0;  // Write only.
            `PONG_REG_STATUS: prdata = {30'd0, overrun, rx_valid};
            default: begin
                rd_ok = 1'b0;
                wr_ok = 1'b0;
            end
        endcase
    end

    assign pslverr = access && (apb.pwrite ? !wr_ok : !rd_ok);

    always_ff @(posedge clk_25MHZ) begin
        if (wr && apb.paddr == `PONG_REG_Y)     rx_pkt.y    <= apb.pwdata[9:0];
        if (wr && apb.paddr == `PONG_REG_VY)    rx_pkt.vy   <= apb.pwdata[7:0];
        if (wr && apb.paddr == `PONG_REG_GRAV)  rx_pkt.grav <= apb.pwdata[1:0];
        if (wr && apb.paddr == `PONG_REG_FLAGS) begin
            rx_pkt.fast <= apb.pwdata[0];
            rx_pkt.win  <= apb.pwdata[1];
        end
    end

    // Commit flag; a second commit before take is lost.
    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            if (rx_take) rx_valid <= 1'b0;
            if (wr && apb.paddr == `PONG_REG_COMMIT && apb.pwdata[0]) begin
                if (rx_valid) overrun <= 1'b1;
                else          rx_valid <= 1'b1;
            end
            if (wr && apb.paddr == `PONG_REG_STATUS && apb.pwdata[1])
                overrun <= 1'b0;  // Write 1 to clear.
        end
    end

    a_take_valid: assert property (@(posedge clk_25MHZ) disable iff (reset)
        rx_take |-> rx_valid)
        else $error("rx_take without a pending packet");

endmodule

`default_nettype wire

//--- paddle_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "pong_link_macros.svh"

module paddle_tracker import pong_geom_pkg::*; (
    input  logic   clk_25MHZ,
    input  logic   reset,
    input  ball_t  ball,
    input  logic   moving_left,
    input  coord_t paddle_y,
    output logic   hit,
    output coord_t paddle_speed
);

    logic [10:0] paddle_bottom;
    logic        on_paddle;
    logic        on_paddle_q;
    logic [9:0]  win_cnt;
    coord_t      last_sample;

    assign paddle_bottom = {1'b0, paddle_y} + 11'(`PONG_PADDLE_H);

    assign on_paddle = moving_left
                    && (ball.x <= `PONG_PADDLE_X)
                    && (ball.y >= paddle_y)
                    && ({1'b0, ball.y} <= paddle_bottom);

    // Rising edge only gives one hit per contact.
    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            on_paddle_q <= 1'b0;
            hit         <= 1'b0;
        end else begin
            on_paddle_q <= on_paddle;
            hit         <= on_paddle && !on_paddle_q;
        end
    end

    // Paddle sampled once per 1024 cycles.
    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            win_cnt      <= '0;
            last_sample  <= '0;
            paddle_speed <= '0;
        end else begin
            win_cnt <= win_cnt + 10'd1;
            if (win_cnt == '1) begin
                last_sample  <= paddle_y;
                paddle_speed <= (paddle_y >= last_sample) ? paddle_y - last_sample
                                                          : last_sample - paddle_y;
            end
        end
    end

    a_hit_single: assert property (@(posedge clk_25MHZ) disable iff (reset)
        hit |=> !hit)
        else $error("hit held for two cycles");

endmodule

`default_nettype wire

//--- pong_board.sv
`timescale 1ns/1ps
`default_nettype none

module pong_board import pong_geom_pkg::*, pong_link_pkg::*; #(
    parameter period_t tick_base = 20'd270000
) (
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic        upscale,
    input  logic        game_start,
    input  coord_t      paddle_y,
    input  apb_req_t    apb,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        send_done,
    output logic        send_req,
    output ball_pkt_t   tx_pkt,
    output logic        game_over,
    output logic        you_win
);

    ball_t     ball;
    logic      moving_left;
    logic      hit;
    coord_t    paddle_speed;
    logic      rx_valid;
    logic      rx_take;
    ball_pkt_t rx_pkt;

    paddle_tracker paddle_tracker_inst (
        .clk_25MHZ    (clk_25MHZ),
        .reset        (reset),
        .ball         (ball),
        .moving_left  (moving_left),
        .paddle_y     (paddle_y),
        .hit          (hit),
        .paddle_speed (paddle_speed)
    );

    link_receiver link_receiver_inst (
        .clk_25MHZ (clk_25MHZ),
        .reset     (reset),
        .apb       (apb),
        .rx_take   (rx_take),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .rx_valid  (rx_valid),
        .rx_pkt    (rx_pkt)
    );

    ball_controller #(
        .tick_base (tick_base)
    ) ball_controller_inst (
        .clk_25MHZ    (clk_25MHZ),
        .reset        (reset),
        .upscale      (upscale),
        .game_start   (game_start),
        .hit          (hit),
        .paddle_speed (paddle_speed),
        .rx_valid     (rx_valid),
        .rx_pkt       (rx_pkt),
        .send_done    (send_done),
        .ball         (ball),
        .moving_left  (moving_left),
        .rx_take      (rx_take),
        .send_req     (send_req),
        .tx_pkt       (tx_pkt),
        .game_over    (game_over),
        .you_win      (you_win)
    );

endmodule

`default_nettype wire

//--- pong_geom_pkg.sv
`default_nettype none

package pong_geom_pkg;

    typedef logic [9:0]        coord_t;   // Screen pixel.
    typedef logic signed [7:0] vel_t;
    typedef logic [1:0]        grav_t;    // Steps until vy grows.
    typedef logic [19:0]       period_t;  // Cycles per step.

    typedef struct packed {
        coord_t x;
        coord_t y;
        vel_t   vy;
        grav_t  grav;
    } ball_t;

    // Match FSM.
    typedef enum logic [2:0] {
        idle,
        wait_release,
        running_right,
        running_left,
        send_ball,
        send_lose,
        stop
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- pong_link.f
+incdir+.
pong_geom_pkg.sv
pong_link_pkg.sv
paddle_tracker.sv
link_receiver.sv
ball_controller.sv
pong_board.sv
tb_pong_board.sv

//--- pong_link_macros.svh
`ifndef PONG_LINK_MACROS_SVH
`define PONG_LINK_MACROS_SVH

// Play field edges.
`define PONG_X_RIGHT_NORMAL 300
`define PONG_X_RIGHT_UP     620
`define PONG_Y_MIN          20
`define PONG_Y_MAX_NORMAL   239
`define PONG_Y_MAX_UP       479

// Ball motion and serve position.
`define PONG_X_STEP         8
`define PONG_Y_START        220
`define PONG_VY_START       (-3)

`define PONG_PADDLE_X       16  // Hit column.
`define PONG_PADDLE_H       48

// APB register window.
`define PONG_REG_Y          8'h00
`define PONG_REG_VY         8'h04
`define PONG_REG_GRAV       8'h08
`define PONG_REG_FLAGS      8'h0C
`define PONG_REG_COMMIT     8'h10
`define PONG_REG_STATUS     8'h14

`endif

//--- pong_link_pkg.sv
`default_nettype none

package pong_link_pkg;

    import pong_geom_pkg::*;

    // Ball as it crosses between boards.
    typedef struct packed {
        coord_t y;
        vel_t   vy;
        grav_t  grav;
        logic   fast;  // Full period when set, half when clear.
        logic   win;
    } ball_pkt_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

endpackage

`default_nettype wire

//--- tb_pong_board.sv
`timescale 1ns/1ps
`default_nettype none

`include "pong_link_macros.svh"

module tb_pong_board import pong_geom_pkg::*, pong_link_pkg::*; ();

    localparam logic [1:0] paddle_random = 2'd0;
    localparam logic [1:0] paddle_away   = 2'd1;
    localparam logic [1:0] paddle_follow = 2'd2;
    localparam period_t    tick_base     = 20'd15;
    localparam ball_t reset_ball = '{x: 10'd0, y: 10'(`PONG_Y_START),
                                     vy: 8'(`PONG_VY_START), grav: 2'd0};

    logic        clk_25MHZ = 1'b0;
    logic        reset;
    logic        upscale;
    logic        game_start;
    coord_t      paddle_y = '0;
    apb_req_t    apb;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        send_done = 1'b0;
    logic        send_req;
    ball_pkt_t   tx_pkt;
    logic        game_over;
    logic        you_win;

    ball_t       ball_now;
    ctrl_state_t state_now;
    ball_t       model_ball;
    ball_pkt_t   pkt_sent;
    logic [1:0]  paddle_mode;
    logic [31:0] lfsr = 32'h3b61_3395;
    logic [5:0]  paddle_tick = '0;
    int unsigned done_wait = 0;
    int          step_gap = 0;
    int          last_gap = 0;
    coord_t      gap_x = '0;

    pong_board #(.tick_base(tick_base)) pong_board_inst (
        .clk_25MHZ  (clk_25MHZ),
        .reset      (reset),
        .upscale    (upscale),
        .game_start (game_start),
        .paddle_y   (paddle_y),
        .apb        (apb),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .send_done  (send_done),
        .send_req   (send_req),
        .tx_pkt     (tx_pkt),
        .game_over  (game_over),
        .you_win    (you_win)
    );

    assign ball_now  = pong_board_inst.ball;
    assign state_now = pong_board_inst.ball_controller_inst.state;

    always #20 clk_25MHZ = ~clk_25MHZ;

    task automatic report_mismatch(input string msg);
        $display("Fail %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Test failures found");
        $fatal(1, "stopped on timeout");
    endtask

    // Fibonacci taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int unsigned val);
        val = 0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    // One ball step from the flight rules.
    function automatic ball_t model_step(input ball_t b, input logic left);
        ball_t n;
        int    ny;
        int    nvy;
        int    ng;
        nvy = int'($signed(b.vy));
        ng  = int'(b.grav);
        if (ng == 3) begin
            nvy = nvy + 1;
            ng  = 0;
        end else begin
            ng = ng + 1;
        end
        ny = int'(b.y) + int'($signed(b.vy));  // Old vy.
        if (ny >= `PONG_Y_MAX_NORMAL || ny <= `PONG_Y_MIN) begin
            ny  = (ny >= `PONG_Y_MAX_NORMAL) ? `PONG_Y_MAX_NORMAL : `PONG_Y_MIN;
            nvy = -nvy;
            ng  = 0;
        end
        n.y    = coord_t'(ny);
        n.vy   = vel_t'(nvy);
        n.grav = grav_t'(ng);
        if (left)
            n.x = (b.x < `PONG_X_STEP) ? 10'd0 : b.x - 10'(`PONG_X_STEP);
        else
            n.x = b.x + 10'(`PONG_X_STEP);
        return n;
    endfunction

    // Model follows the serve or the accepted packet.
    always @(negedge clk_25MHZ) begin
        if (state_now == idle)
            model_ball = reset_ball;
        else if (state_now == wait_release)
            model_ball = '{x: 10'(`PONG_X_RIGHT_NORMAL), y: pkt_sent.y,
                           vy: pkt_sent.vy, grav: pkt_sent.grav};
        else if ((state_now == running_right || state_now == running_left)
                 && ball_now.x != model_ball.x)
            model_ball = model_step(model_ball, state_now == running_left);
    end

    // Cycles between the last two ball steps.
    always @(negedge clk_25MHZ) begin
        if (state_now != running_right && state_now != running_left) begin
            step_gap = 0;
        end else if (ball_now.x != gap_x) begin
            last_gap = step_gap;
            step_gap = 1;
        end else begin
            step_gap = step_gap + 1;
        end
        gap_x = ball_now.x;
    end

    // Link master and paddle.
    always begin : link_and_paddle
        logic [1:0]  mode;
        int unsigned draw;
        @(posedge clk_25MHZ);
        mode = paddle_mode;
        #2;
        if (send_done) begin
            send_done = 1'b0;
        end else if (done_wait != 0) begin
            done_wait = done_wait - 1;
            if (done_wait == 0) send_done = 1'b1;
        end else if (send_req) begin
            take_bits(3, draw);
            done_wait = draw + 1;  // 1 to 8 cycles.
        end
        if (mode == paddle_random) begin
            if (paddle_tick == 0) begin
                take_bits(8, draw);
                paddle_y = coord_t'(draw);
            end
        end else if (mode == paddle_away) begin
            paddle_y = 10'd400;
        end else begin
            paddle_y = (model_ball.y > 10'd24) ? model_ball.y - 10'd24 : 10'd0;
        end
        paddle_tick = paddle_tick + 6'd1;
    end

    a_flight: assert property (@(posedge clk_25MHZ) disable iff (reset)
        (state_now == running_right || state_now == running_left) |-> ball_now == model_ball)
        else report_mismatch($sformatf("ball x %0d y %0d, model x %0d y %0d",
                             ball_now.x, ball_now.y, model_ball.x, model_ball.y));

    a_field: assert property (@(posedge clk_25MHZ) disable iff (reset)
        ball_now.y >= `PONG_Y_MIN && ball_now.y <= `PONG_Y_MAX_NORMAL)
        else report_mismatch($sformatf("ball y %0d off the field", ball_now.y));

    a_tx_ball: assert property (@(posedge clk_25MHZ) disable iff (reset)
        state_now == send_ball |-> send_req && !tx_pkt.win && tx_pkt.y == model_ball.y
            && tx_pkt.vy == model_ball.vy && tx_pkt.grav == model_ball.grav
            && tx_pkt.fast == (last_gap == int'(tick_base) + 1))
        else report_mismatch("outgoing ball packet wrong");

    a_tx_lose: assert property (@(posedge clk_25MHZ) disable iff (reset)
        state_now == send_lose |-> send_req && game_over && tx_pkt.win
            && tx_pkt.y == model_ball.y && tx_pkt.fast == (last_gap == int'(tick_base) + 1))
        else report_mismatch("lose packet wrong");

    a_req_hold: assert property (@(posedge clk_25MHZ) disable iff (reset)
        send_req && !send_done |=> send_req)
        else report_mismatch("send_req fell before send_done");

    a_req_drop: assert property (@(posedge clk_25MHZ) disable iff (reset)
        send_req && send_done |=> !send_req)
        else report_mismatch("send_req held after send_done");

    a_pready: assert property (@(posedge clk_25MHZ) disable iff (reset)
        apb.psel && apb.penable |-> pready)
        else report_mismatch("pready low in the access phase");

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        apb = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk_25MHZ);
        #2;
        apb.penable = 1'b1;
        @(negedge clk_25MHZ);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_25MHZ);
        #2;
        apb = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        if (err) report_mismatch($sformatf("pslverr on write to 0x%02h", addr));
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        if (err) report_mismatch($sformatf("pslverr on read of 0x%02h", addr));
    endtask

    task automatic write_packet(input ball_pkt_t pkt);
        apb_write(`PONG_REG_Y, 32'(pkt.y));
        apb_write(`PONG_REG_VY, 32'($signed(pkt.vy)));
        apb_write(`PONG_REG_GRAV, 32'(pkt.grav));
        apb_write(`PONG_REG_FLAGS, {30'd0, pkt.win, pkt.fast});
    endtask

    task automatic wait_state(input ctrl_state_t target, input int limit, input string what);
        int n;
        n = 0;
        while (state_now != target && n < limit) begin
            @(posedge clk_25MHZ);
            #2;
            n++;
        end
        if (state_now != target) report_timeout(what);
    endtask

    task automatic pulse_start();
        game_start = 1'b1;
        @(posedge clk_25MHZ);
        #2;
        game_start = 1'b0;
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        reset       = 1'b1;
        upscale     = 1'b0;
        game_start  = 1'b0;
        apb         = '0;
        pkt_sent    = '0;
        paddle_mode = paddle_random;
        repeat (5) @(posedge clk_25MHZ);
        #2;
        reset = 1'b0;
        @(posedge clk_25MHZ);
        #2;
        if (state_now != idle || ball_now != reset_ball || send_req || game_over || you_win)
            report_mismatch("state after reset");

        // Serve to the right; the opponent's packet waits meanwhile.
        pulse_start();
        wait_state(running_right, 4, "serve");
        pkt_sent = '{y: 10'd100, vy: 8'd2, grav: 2'd1, fast: 1'b0, win: 1'b0};
        write_packet(pkt_sent);
        apb_write(`PONG_REG_COMMIT, 32'd1);
        apb_read(`PONG_REG_STATUS, rdata);
        if (rdata[1:0] != 2'b01) report_mismatch($sformatf("status %0h after commit", rdata));
        apb_write(`PONG_REG_COMMIT, 32'd1);
        apb_read(`PONG_REG_STATUS, rdata);
        if (rdata[1:0] != 2'b11) report_mismatch("overrun bit not set");
        apb_access(1'b1, 8'h20, 32'd0, rdata, err);
        if (!err) report_mismatch("no pslverr at offset 0x20");
        apb_write(`PONG_REG_STATUS, 32'd2);
        apb_read(`PONG_REG_STATUS, rdata);
        if (rdata[1:0] != 2'b01) report_mismatch("overrun bit not cleared");
        paddle_mode = paddle_away;
        wait_state(send_ball, 2000, "ball at the right edge");
        wait_state(idle, 40, "end of the hand-off");

        // Incoming ball with no paddle in the way.
        wait_state(wait_release, 4, "packet acceptance");
        if (ball_now.x != `PONG_X_RIGHT_NORMAL || ball_now.y != pkt_sent.y)
            report_mismatch($sformatf("ball placed at x %0d y %0d", ball_now.x, ball_now.y));
        wait_state(send_lose, 2000, "ball at the left edge");
        wait_state(stop, 40, "end of the lose packet");
        if (!game_over || send_req) report_mismatch("game_over not held in stop");
        pulse_start();
        wait_state(idle, 4, "restart after the lost match");
        if (game_over) report_mismatch("game_over still high after restart");

        // Paddle on the ball's row.
        pkt_sent    = '{y: 10'd150, vy: 8'd0, grav: 2'd0, fast: 1'b1, win: 1'b0};
        paddle_mode = paddle_follow;
        write_packet(pkt_sent);
        apb_write(`PONG_REG_COMMIT, 32'd1);
        wait_state(running_left, 10, "second packet acceptance");
        wait_state(running_right, 2000, "paddle return");
        if (ball_now.x > `PONG_PADDLE_X)
            report_mismatch($sformatf("ball turned at x %0d", ball_now.x));
        wait_state(send_ball, 2000, "returned ball at the right edge");
        wait_state(idle, 40, "end of the second hand-off");

        // Winning packet from the opponent.
        pkt_sent = '{y: 10'd120, vy: 8'd0, grav: 2'd0, fast: 1'b1, win: 1'b1};
        write_packet(pkt_sent);
        apb_write(`PONG_REG_COMMIT, 32'd1);
        wait_state(wait_release, 10, "winning packet acceptance");
        wait_state(idle, 4, "return to idle after the win");
        if (!you_win) report_mismatch("you_win not set by a winning packet");

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
